//--- rtl/alu_pkg.sv
package alu_pkg;

    // Operand and result width, tied to the 4-bit shift amount
    localparam int DATA_W = 16;

    localparam int NUM_LANES_DEF = 4; // Lanes in the array unless overridden

    typedef logic [DATA_W-1:0] data_t; // Operands and results

    // Upper two bits select the group
    // 00 arithmetic, 01 logic, 10 shift, 11 set condition
    typedef enum logic [4:0] {
        // Arithmetic, all on the shared adder
        OP_ADD  = 5'b00_000, // A + B
        OP_ADDU = 5'b00_001, // A + B, same bits as add
        OP_SUB  = 5'b00_010, // A - B
        OP_SUBU = 5'b00_011, // A - B, same bits as sub
        OP_INC  = 5'b00_100, // A + 1
        OP_DEC  = 5'b00_101, // A - 1

        // Logic
        OP_AND  = 5'b01_000, // A & B
        OP_OR   = 5'b01_001, // A | B
        OP_XOR  = 5'b01_010, // A ^ B
        OP_NOT  = 5'b01_100, // ~A, B ignored

        // Shift by B[3:0]
        OP_SLL  = 5'b10_000, // Zero fill from the right
        OP_SRL  = 5'b10_001, // Zero fill from the left
        OP_SLA  = 5'b10_010, // Same as sll
        OP_SRA  = 5'b10_011, // Sign fill from the left

        // Set condition, signed compare, result 1 or 0
        OP_SLE  = 5'b11_000, // A <= B
        OP_SLT  = 5'b11_001, // A < B
        OP_SGE  = 5'b11_010, // A >= B
        OP_SGT  = 5'b11_011, // A > B
        OP_SEQ  = 5'b11_100, // A == B
        OP_SNE  = 5'b11_101  // A != B
    } alu_op_e;

endpackage

//--- rtl/alu_lane_if.sv
interface alu_lane_if;

    logic              valid; // Transfer offered
    logic              ready; // Transfer accepted
    alu_pkg::alu_op_e  op;    // Operation code
    alu_pkg::data_t    a;     // First operand
    alu_pkg::data_t    b;     // Second operand, shift amount in [3:0]
    alu_pkg::data_t    res;   // Lane result

    // Dispatcher side of an operation transfer
    modport issue    (output valid, output op, output a, output b, input ready);

    // Lane side of an operation transfer
    modport exec_in  (input valid, input op, input a, input b, output ready);

    // Collector side of a result transfer
    modport drain    (input valid, input res, output ready);

    // Lane side of a result transfer
    modport exec_out (output valid, output res, input ready);

endinterface

//--- rtl/alu_lane.sv
module alu_lane (
    input  logic         clk,
    input  logic         rst_n,
    alu_lane_if.exec_in  req,
    alu_lane_if.exec_out rsp
);

    alu_pkg::data_t add_b;    // Second adder input after op select
    logic           add_cin;  // Carry in, set for subtract
    alu_pkg::data_t add_sum;  // Shared adder output
    alu_pkg::data_t alu_res;  // Decoded result before the register
    logic           set_bit;  // Outcome of the set condition

    alu_pkg::data_t res_q;    // Result slot
    logic           valid_q;  // Slot holds a result

    logic           take;     // Operation accepted this cycle

    // Adder operand select
    // inc adds one, dec adds all ones, sub adds ~B plus carry
    always_comb
    begin
        add_b   = req.b;
        add_cin = 1'b0;
        case (req.op)
            alu_pkg::OP_SUB,
            alu_pkg::OP_SUBU:
            begin
                add_b   = ~req.b;
                add_cin = 1'b1;
            end
            alu_pkg::OP_INC: add_b = alu_pkg::data_t'(1);
            alu_pkg::OP_DEC: add_b = '1;                   // Minus one in two's complement
            default:         add_b = req.b;
        endcase
    end

    assign add_sum = req.a + add_b + alu_pkg::data_t'(add_cin); // Wraps modulo 2^16

    // Signed compares for the set group
    always_comb
    begin
        case (req.op)
            alu_pkg::OP_SLE: set_bit = ($signed(req.a) <= $signed(req.b));
            alu_pkg::OP_SLT: set_bit = ($signed(req.a) <  $signed(req.b));
            alu_pkg::OP_SGE: set_bit = ($signed(req.a) >= $signed(req.b));
            alu_pkg::OP_SGT: set_bit = ($signed(req.a) >  $signed(req.b));
            alu_pkg::OP_SEQ: set_bit = (req.a == req.b);
            alu_pkg::OP_SNE: set_bit = (req.a != req.b);
            default:         set_bit = 1'b0;
        endcase
    end

    // Main decode
    always_comb
    begin
        case (req.op)
            alu_pkg::OP_ADD,
            alu_pkg::OP_ADDU,
            alu_pkg::OP_SUB,
            alu_pkg::OP_SUBU,
            alu_pkg::OP_INC,
            alu_pkg::OP_DEC:  alu_res = add_sum;

            alu_pkg::OP_AND:  alu_res = req.a & req.b;
            alu_pkg::OP_OR:   alu_res = req.a | req.b;
            alu_pkg::OP_XOR:  alu_res = req.a ^ req.b;
            alu_pkg::OP_NOT:  alu_res = ~req.a;

            alu_pkg::OP_SLL,
            alu_pkg::OP_SLA:  alu_res = req.a << req.b[3:0];  // Left shifts are identical
            alu_pkg::OP_SRL:  alu_res = req.a >> req.b[3:0];
            alu_pkg::OP_SRA:  alu_res = alu_pkg::data_t'($signed(req.a) >>> req.b[3:0]);

            alu_pkg::OP_SLE,
            alu_pkg::OP_SLT,
            alu_pkg::OP_SGE,
            alu_pkg::OP_SGT,
            alu_pkg::OP_SEQ,
            alu_pkg::OP_SNE:  alu_res = alu_pkg::data_t'(set_bit);

            default:          alu_res = '0;                    // Unused codes
        endcase
    end

    // Slot free, or emptied by the collector this cycle
    assign req.ready = !valid_q || rsp.ready;
    assign take      = req.valid && req.ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (take)
        begin
            valid_q <= 1'b1;                                   // Refill wins over drain
        end
        else if (rsp.ready)
        begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            res_q <= alu_res;
        end
    end

    assign rsp.valid = valid_q;
    assign rsp.res   = res_q;

endmodule

//--- rtl/op_dispatch.sv
module op_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  alu_pkg::alu_op_e in_op,
    input  alu_pkg::data_t   in_a,
    input  alu_pkg::data_t   in_b,
    alu_lane_if.issue        lanes [NUM_LANES]
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0]     ptr_q;     // Lane due for the next operation
    logic [NUM_LANES-1:0] ready_vec; // Lane readies gathered for indexing

    // Valid only to the named lane, payload fans out to all
    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        assign lanes[i].valid = in_valid && (ptr_q == PTR_W'(i));
        assign lanes[i].op    = in_op;
        assign lanes[i].a     = in_a;
        assign lanes[i].b     = in_b;
        assign ready_vec[i]   = lanes[i].ready;
    end

    assign in_ready = ready_vec[ptr_q];  // Stalls when the due lane is full

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ptr_q <= '0;
        end
        else if (in_valid && in_ready)
        begin
            // Wrap after the last lane
            ptr_q <= (ptr_q == PTR_W'(NUM_LANES - 1)) ? '0 : ptr_q + PTR_W'(1);
        end
    end

endmodule

//--- rtl/result_collect.sv
module result_collect #(
    parameter int NUM_LANES = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    alu_lane_if.drain      lanes [NUM_LANES],
    output logic           out_valid,
    input  logic           out_ready,
    output alu_pkg::data_t out_res
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0]     ptr_q;                // Lane due to drain next
    logic [NUM_LANES-1:0] valid_vec;            // Lane valids gathered
    alu_pkg::data_t       res_vec [NUM_LANES];  // Lane results gathered

    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        assign valid_vec[i]   = lanes[i].valid;
        assign res_vec[i]     = lanes[i].res;
        assign lanes[i].ready = out_ready && (ptr_q == PTR_W'(i)); // Only the due lane drains
    end

    // Same order as dispatch, so no tags needed
    assign out_valid = valid_vec[ptr_q];
    assign out_res   = res_vec[ptr_q];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ptr_q <= '0;
        end
        else if (out_valid && out_ready)
        begin
            ptr_q <= (ptr_q == PTR_W'(NUM_LANES - 1)) ? '0 : ptr_q + PTR_W'(1); // Wrap
        end
    end

endmodule

//--- rtl/alu_array_top.sv
module alu_array_top #(
    parameter int NUM_LANES = alu_pkg::NUM_LANES_DEF
) (
    input  logic             clk,
    input  logic             rst_n,

    // Operation input
    input  logic             in_valid,
    output logic             in_ready,
    input  alu_pkg::alu_op_e in_op,
    input  alu_pkg::data_t   in_a,
    input  alu_pkg::data_t   in_b,

    // Result output, in arrival order
    output logic             out_valid,
    input  logic             out_ready,
    output alu_pkg::data_t   out_res
);

    alu_lane_if issue_if [NUM_LANES] ();  // Dispatcher to lanes
    alu_lane_if drain_if [NUM_LANES] ();  // Lanes to collector

    op_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) u_dispatch (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_op    (in_op),
        .in_a     (in_a),
        .in_b     (in_b),
        .lanes    (issue_if)
    );

    // One registered ALU per lane
    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        alu_lane u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (issue_if[i]),
            .rsp   (drain_if[i])
        );
    end

    result_collect #(
        .NUM_LANES (NUM_LANES)
    ) u_collect (
        .clk       (clk),
        .rst_n     (rst_n),
        .lanes     (drain_if),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

endmodule

//--- tests/tb_clock.sv
module tb_clock #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;  // 50% duty
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                     // Released on an edge, DUT reset is synchronous
    end

endmodule

//--- tests/tb_checker.sv
module tb_checker (
    input  logic             clk,
    input  logic             in_valid,
    input  logic             in_ready,
    input  alu_pkg::alu_op_e in_op,
    input  alu_pkg::data_t   in_a,
    input  alu_pkg::data_t   in_b,
    input  logic             exp_known,  // Table value given with the operation
    input  alu_pkg::data_t   exp_res,
    input  logic             out_valid,
    input  logic             out_ready,
    input  alu_pkg::data_t   out_res,
    output int               chk_cnt,
    output int               err_cnt,
    output int               pending
);

    alu_pkg::data_t exp_q [$];          // Expected results in input order
    alu_pkg::data_t want;
    alu_pkg::data_t held_res;           // Result shown during a stall
    logic           held   = 1'b0;      // Last sample was a stall
    int             checks = 0;
    int             errs   = 0;
    int             depth  = 0;

    assign chk_cnt = checks;
    assign err_cnt = errs;
    assign pending = depth;

    // Expected result from the operation rules
    function automatic alu_pkg::data_t model(input alu_pkg::alu_op_e op,
                                             input alu_pkg::data_t a,
                                             input alu_pkg::data_t b);
        int             n;
        alu_pkg::data_t r;
        begin
            n = int'(b[3:0]);           // Shift amount
            case (op)
                alu_pkg::OP_ADD, alu_pkg::OP_ADDU: r = a + b;     // Wraps
                alu_pkg::OP_SUB, alu_pkg::OP_SUBU: r = a - b;
                alu_pkg::OP_INC:  r = a + 16'd1;
                alu_pkg::OP_DEC:  r = a - 16'd1;
                alu_pkg::OP_AND:  r = a & b;
                alu_pkg::OP_OR:   r = a | b;
                alu_pkg::OP_XOR:  r = a ^ b;
                alu_pkg::OP_NOT:  r = ~a;
                alu_pkg::OP_SLL, alu_pkg::OP_SLA: r = a << n;
                alu_pkg::OP_SRL:  r = a >> n;
                alu_pkg::OP_SRA:  r = (a >> n) | (a[15] ? ~(16'hFFFF >> n) : 16'h0000);
                alu_pkg::OP_SLE:  r = {15'd0, ($signed(a) <= $signed(b))};
                alu_pkg::OP_SLT:  r = {15'd0, ($signed(a) < $signed(b))};
                alu_pkg::OP_SGE:  r = {15'd0, ($signed(a) >= $signed(b))};
                alu_pkg::OP_SGT:  r = {15'd0, ($signed(a) > $signed(b))};
                alu_pkg::OP_SEQ:  r = {15'd0, (a == b)};
                alu_pkg::OP_SNE:  r = {15'd0, (a != b)};
                default:          r = '0;                          // Unused codes
            endcase
            return r;
        end
    endfunction

    // Mid-cycle sampling, handshakes settled
    always @(negedge clk)
    begin
        if (held && !out_valid)
        begin
            $display("Error at %0t: out_valid dropped while the result was stalled", $time);
            errs++;
        end
        else if (held && out_res !== held_res)
        begin
            $display("Fail at %0t: out_res expected 0x%04h actual 0x%04h", $time, held_res, out_res);
            errs++;
        end
        held     = out_valid && !out_ready;
        held_res = out_res;
        if (out_valid && out_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Error at %0t: result 0x%04h came with no operation outstanding",
                         $time, out_res);
                errs++;
            end
            else
            begin
                want = exp_q.pop_front();
                checks++;
                if (out_res !== want)
                begin
                    $display("Fail at %0t: out_res expected 0x%04h actual 0x%04h",
                             $time, want, out_res);
                    errs++;
                end
            end
        end
        if (in_valid && in_ready)
        begin
            exp_q.push_back(exp_known ? exp_res : model(in_op, in_a, in_b));
        end
        depth = exp_q.size();
    end

endmodule

//--- tests/tb_alu_array.sv
module tb_alu_array;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_LANES  = alu_pkg::NUM_LANES_DEF;
    localparam int N_DIR      = 25;
    localparam int N_ROWS     = N_DIR + 40;  // Directed rows, then random ones
    localparam int TIMEOUT    = 100;         // Cycles allowed per wait

    typedef struct packed {
        logic             known;  // Row carries its expected result
        alu_pkg::alu_op_e op;
        alu_pkg::data_t   a;
        alu_pkg::data_t   b;
        alu_pkg::data_t   res;
    } row_t;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic             in_ready;
    alu_pkg::alu_op_e in_op;
    alu_pkg::data_t   in_a;
    alu_pkg::data_t   in_b;
    logic             out_valid;
    logic             out_ready  = 1'b1;
    alu_pkg::data_t   out_res;
    logic             exp_known;         // Travels with each operation
    alu_pkg::data_t   exp_res;
    logic             stall_rand = 1'b0; // Random out_ready
    logic             ready_hold = 1'b1; // Fixed out_ready level
    int               chk_cnt;
    int               err_cnt;
    int               pending;
    int               tb_errs    = 0;    // Timeouts and timing faults
    int               base_chk   = 0;
    int               base_err   = 0;
    int               idx;
    int               accepted;
    logic             stalled;
    time              t0;
    row_t             tab [N_ROWS];

    tb_clock #(.PERIOD(CLK_PERIOD)) clk_gen_i (.*);

    alu_array_top #(.NUM_LANES(NUM_LANES)) dut_i (.*);

    tb_checker chk_i (.*);

    always @(posedge clk)
    begin
        out_ready <= stall_rand ? 1'($urandom) : ready_hold;
    end

    task automatic load_table();
        begin
            tab[0]  = '{1'b1, alu_pkg::OP_ADD,  16'h1234, 16'h0FF0, 16'h2224};
            tab[1]  = '{1'b1, alu_pkg::OP_ADDU, 16'hFFFF, 16'h0001, 16'h0000}; // Wraps to zero
            tab[2]  = '{1'b1, alu_pkg::OP_SUB,  16'h0000, 16'h0001, 16'hFFFF};
            tab[3]  = '{1'b1, alu_pkg::OP_SUBU, 16'h8000, 16'h0001, 16'h7FFF};
            tab[4]  = '{1'b1, alu_pkg::OP_INC,  16'hFFFF, 16'h1234, 16'h0000};
            tab[5]  = '{1'b1, alu_pkg::OP_DEC,  16'h0000, 16'h5555, 16'hFFFF};
            tab[6]  = '{1'b1, alu_pkg::OP_ADD,  16'h7FFF, 16'h0001, 16'h8000};
            tab[7]  = '{1'b1, alu_pkg::OP_AND,  16'hF0F0, 16'h3C3C, 16'h3030};
            tab[8]  = '{1'b1, alu_pkg::OP_OR,   16'hF0F0, 16'h3C3C, 16'hFCFC};
            tab[9]  = '{1'b1, alu_pkg::OP_XOR,  16'hFFFF, 16'h5A5A, 16'hA5A5};
            tab[10] = '{1'b1, alu_pkg::OP_NOT,  16'h00FF, 16'hFFFF, 16'hFF00}; // B ignored
            tab[11] = '{1'b1, alu_pkg::OP_SLL,  16'h8001, 16'h0000, 16'h8001}; // Amount 0
            tab[12] = '{1'b1, alu_pkg::OP_SLL,  16'h0003, 16'h000F, 16'h8000}; // Amount 15
            tab[13] = '{1'b1, alu_pkg::OP_SLA,  16'h0003, 16'h0011, 16'h0006}; // Only B[3:0]
            tab[14] = '{1'b1, alu_pkg::OP_SRL,  16'h8000, 16'h000F, 16'h0001};
            tab[15] = '{1'b1, alu_pkg::OP_SRA,  16'h8000, 16'h000F, 16'hFFFF}; // Sign fill
            tab[16] = '{1'b1, alu_pkg::OP_SRA,  16'h7FFF, 16'h0014, 16'h07FF};
            tab[17] = '{1'b1, alu_pkg::OP_SLT,  16'h8000, 16'h0001, 16'h0001}; // Signed
            tab[18] = '{1'b1, alu_pkg::OP_SLT,  16'h0001, 16'h8000, 16'h0000};
            tab[19] = '{1'b1, alu_pkg::OP_SLE,  16'h1234, 16'h1234, 16'h0001};
            tab[20] = '{1'b1, alu_pkg::OP_SGE,  16'h7FFF, 16'h8000, 16'h0001};
            tab[21] = '{1'b1, alu_pkg::OP_SGT,  16'hFFFF, 16'h0000, 16'h0000}; // -1 vs 0
            tab[22] = '{1'b1, alu_pkg::OP_SEQ,  16'hFFFF, 16'hFFFF, 16'h0001};
            tab[23] = '{1'b1, alu_pkg::OP_SNE,  16'h0000, 16'h0000, 16'h0000};
            tab[24] = '{1'b1, alu_pkg::alu_op_e'(5'b00_111), 16'hFFFF, 16'hFFFF, 16'h0000};
            for (int i = N_DIR; i < N_ROWS; i++)
            begin
                // Any 5-bit code, unused ones included
                tab[i] = '{1'b0, alu_pkg::alu_op_e'(5'($urandom)), 16'($urandom),
                           16'($urandom), 16'h0000};
            end
        end
    endtask

    task automatic drive_row(input int i);
        begin
            in_valid  <= 1'b1;
            in_op     <= tab[i].op;
            in_a      <= tab[i].a;
            in_b      <= tab[i].b;
            exp_known <= tab[i].known;
            exp_res   <= tab[i].res;
        end
    endtask

    // Returns just after the edge that takes the row
    task automatic send_row(input int i);
        int waited;
        begin
            waited = 0;
            drive_row(i);
            @(negedge clk);
            while (!in_ready && waited < TIMEOUT)
            begin
                @(negedge clk);
                waited++;
            end
            if (!in_ready)
            begin
                $display("Error at %0t: operation %0d was never accepted", $time, i);
                tb_errs++;
            end
            @(posedge clk);
        end
    endtask

    task automatic run_rows(input int first, input int count);
        for (int i = first; i < first + count; i++)
        begin
            send_row(i);
        end
    endtask

    task automatic wait_drained();
        int waited;
        begin
            waited = 0;
            in_valid <= 1'b0;
            @(posedge clk);
            while (pending != 0 && waited < TIMEOUT)
            begin
                @(posedge clk);
                waited++;
            end
            if (pending != 0)
            begin
                $display("Error at %0t: %0d results never came out", $time, pending);
                tb_errs++;
            end
        end
    endtask

    task automatic check_val(input string name, input int want, input int got);
        if (want !== got)
        begin
            $display("Fail at %0t: %s expected %0d actual %0d", $time, name, want, got);
            tb_errs++;
        end
    endtask

    task automatic group_done(input string name);
        begin
            $display("%s: %0d results checked, %0d errors", name, chk_cnt - base_chk,
                     err_cnt + tb_errs - base_err);
            base_chk = chk_cnt;
            base_err = err_cnt + tb_errs;
        end
    endtask

    initial
    begin
        in_valid  <= 1'b0;
        in_op     <= alu_pkg::OP_ADD;
        in_a      <= '0;
        in_b      <= '0;
        exp_known <= 1'b0;
        exp_res   <= '0;
        void'($urandom(43));
        load_table();
        idx = 0;
        @(posedge clk);
        while (!rst_n && idx < TIMEOUT)
        begin
            @(posedge clk);
            idx++;
        end
        if (!rst_n)
        begin
            $display("Error at %0t: reset was never released", $time);
            tb_errs++;
        end

        run_rows(0, 7);
        wait_drained();
        group_done("arithmetic");
        run_rows(7, 10);
        wait_drained();
        group_done("logic and shift");
        run_rows(17, 8);
        wait_drained();
        group_done("set and unused codes");

        send_row(0);                     // Lone operation, out_ready high
        in_valid <= 1'b0;
        @(negedge clk);
        check_val("out_valid 1 cycle after accept", 1, int'(out_valid));
        @(negedge clk);
        check_val("out_valid 2 cycles after accept", 0, int'(out_valid));
        wait_drained();
        t0 = $time;
        run_rows(N_DIR, 8);              // Should take one cycle each
        check_val("cycles for 8 streamed operations", 8, int'(($time - t0) / CLK_PERIOD));
        wait_drained();
        group_done("latency and streaming");

        ready_hold <= 1'b0;
        @(posedge clk);                  // out_ready low from here on
        idx      = N_DIR + 8;
        accepted = 0;
        stalled  = 1'b0;
        while (!stalled && accepted <= NUM_LANES)
        begin
            drive_row(idx);
            @(negedge clk);
            if (in_ready)
            begin
                accepted++;
                idx++;
                @(posedge clk);
            end
            else
            begin
                stalled = 1'b1;
            end
        end
        check_val("operations accepted with out_ready low", NUM_LANES, accepted);
        repeat (3)
        begin
            @(negedge clk);
            check_val("in_ready with all lanes full", 0, int'(in_ready));
        end
        @(posedge clk);
        ready_hold <= 1'b1;
        send_row(idx);                   // Offer held through the stall
        idx++;
        wait_drained();
        group_done("back-pressure");

        stall_rand <= 1'b1;
        run_rows(idx, N_ROWS - idx);
        stall_rand <= 1'b0;
        wait_drained();
        group_done("random stalls");

        check_val("results checked in total", N_ROWS + 1, chk_cnt);
        $display("Totals: %0d results checked, %0d errors", chk_cnt, err_cnt + tb_errs);
        if (err_cnt + tb_errs == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- all.f
rtl/alu_pkg.sv
rtl/alu_lane_if.sv
rtl/alu_lane.sv
rtl/op_dispatch.sv
rtl/result_collect.sv
rtl/alu_array_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_alu_array.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the ALU array testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --top-module tb_alu_array -f all.f -o tb_alu_array; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_alu_array 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
